// File: sources.f
design/uart_pkg.sv
design/uart_regs.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
verif/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - design/uart_pkg.sv
  - design/uart_regs.sv
  - design/uart_baud_gen.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/uart_top.sv
  - target: simulation
    files:
      - verif/uart_tb.sv

// File: verif/uart_tb.sv
// ==============================
// uart_tb
// random-stimulus testbench for the UART
// with a register model and a serial line model
// ==============================

module uart_tb
    import uart_pkg::*;
();

    logic           clk;
    logic           rst;
    uart_word_t     addr;
    logic           we;
    uart_word_t     wd;
    uart_word_t     rd;
    logic           tx_line;
    logic           rx_line;        // driven serial frames
    logic           loop_en;        // route tx back to rx
    logic           rx_in;

    // register model
    logic [7 : 0]   cr_m;
    uart_data_t     tx_m;
    uart_data_t     rx_m;
    logic [15 : 0]  div_m;

    int             word_errors;
    int             byte_errors;
    int             other_errors;

    assign rx_in = loop_en ? tx_line : rx_line;

    uart_top #(.DIV_W(16)) i_dut
    (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .addr       ( addr      ),
        .we         ( we        ),
        .wd         ( wd        ),
        .rd         ( rd        ),
        .uart_tx    ( tx_line   ),
        .uart_rx    ( rx_in     )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7 : 0] cr_write(input logic [7 : 0] old, input uart_word_t data);
        logic [7 : 0] nxt;
        nxt = old;
        nxt[2 : 0] = data[2 : 0];               // req, tr_en, rec_en
        if (data[CR_RX_VALID])
            nxt[CR_RX_VALID] = 1'b0;
        if (data[CR_FRAME_ERR])
            nxt[CR_FRAME_ERR] = 1'b0;
        nxt[7 : 5] = '0;
        return nxt;
    endfunction

    function automatic uart_word_t expected_read(input logic [3 : 0] off);
        case (off)
            UART_CR : return uart_word_t'(cr_m);
            UART_TX : return uart_word_t'(tx_m);
            UART_RX : return uart_word_t'(rx_m);
            UART_DR : return uart_word_t'(div_m);
            default : return '0;
        endcase
    endfunction

    task automatic compare_word(input string name, input uart_word_t got, input uart_word_t exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic compare_byte(input string name, input uart_data_t got, input uart_data_t exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            byte_errors++;
        end
    endtask

    // upper address bits are don't care
    task automatic write_reg(input logic [3 : 0] off, input uart_word_t data);
        @(posedge clk);
        addr <= {28'($urandom), off};
        wd   <= data;
        we   <= 1'b1;
        @(posedge clk);
        we   <= 1'b0;
        case (off)
            UART_CR : cr_m = cr_write(cr_m, data);
            UART_TX : tx_m = data[7 : 0];
            UART_DR : div_m = data[15 : 0];
            default : ;
        endcase
    endtask

    task automatic read_reg(input logic [3 : 0] off, output uart_word_t val);
        @(posedge clk);
        addr <= {28'($urandom), off};
        @(negedge clk);
        val = rd;                               // settled read data
    endtask

    task automatic check_reg(input logic [3 : 0] off, input string name);
        uart_word_t v;
        read_reg(off, v);
        compare_word(name, v, expected_read(off));
    endtask

    task automatic check_all();
        logic [3 : 0] off;
        off = {2'($urandom), 2'($urandom % 3 + 1)};     // never a mapped offset
        check_reg(UART_CR, "cr");
        check_reg(UART_TX, "tx_data");
        check_reg(UART_RX, "rx_data");
        check_reg(UART_DR, "div");
        check_reg(off, "unmapped read");
    endtask

    task automatic wait_cr(input int pos, input logic val, input int limit, input string what);
        uart_word_t v;
        int         n;
        n = 0;
        read_reg(UART_CR, v);
        while ((v[pos] !== val) && (n < limit))
        begin
            read_reg(UART_CR, v);
            n++;
        end
        if (v[pos] !== val)
        begin
            $display("timeout while waiting for %s", what);
            other_errors++;
        end
    endtask

    // line model receive side samples uart_tx at mid-bit
    task automatic decode_frame(input int d, output uart_data_t b, output bit ok);
        int n;
        int i;
        ok = 1'b0;
        b  = '0;
        n  = 0;
        @(negedge clk);
        while ((tx_line !== 1'b0) && (n < 4 * d))
        begin
            @(negedge clk);
            n++;
        end
        if (tx_line !== 1'b0)
        begin
            $display("timeout: no start bit appeared on uart_tx");
            other_errors++;
            return;
        end
        repeat (d / 2) @(negedge clk);
        if (tx_line !== 1'b0)
        begin
            $display("start bit on uart_tx did not stay low to mid-bit");
            other_errors++;
            return;
        end
        for (i = 0; i < 8; i++)
        begin
            repeat (d) @(negedge clk);
            b[i] = tx_line;                     // lsb first
        end
        repeat (d) @(negedge clk);
        if (tx_line !== 1'b1)
        begin
            $display("stop bit on uart_tx was low");
            other_errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic expect_no_start(input int d);
        bit started;
        int i;
        started = 1'b0;
        for (i = 0; i < 12 * d; i++)
        begin
            @(negedge clk);
            if (tx_line !== 1'b1)
                started = 1'b1;
        end
        if (started)
        begin
            $display("uart_tx sent a start bit with the transmitter disabled");
            other_errors++;
        end
    endtask

    // line model transmit side holds each bit for d cycles
    task automatic send_frame(input int d, input uart_data_t b, input logic stop);
        logic [9 : 0] bits;
        int           i;
        bits = {stop, b, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rx_line <= bits[i];
            repeat (d - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_line <= 1'b1;                        // back to idle
        repeat (d) @(posedge clk);
    endtask

    initial
    begin
        uart_word_t data;
        uart_data_t b;
        uart_data_t got;
        logic [3 : 0] off;
        bit         ok;
        int         d;
        int         i;

        void'($urandom(33711));
        rst     = 1'b1;
        addr    = '0;
        we      = 1'b0;
        wd      = '0;
        rx_line = 1'b1;
        loop_en = 1'b0;
        cr_m    = '0;
        tx_m    = '0;
        rx_m    = '0;
        div_m   = '0;
        word_errors  = 0;
        byte_errors  = 0;
        other_errors = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // register readback
        check_all();
        for (i = 0; i < 40; i++)
        begin
            off  = 4'($urandom);
            data = $urandom;
            if (off == UART_CR)
                data[CR_TR_EN] = 1'b0;          // keep the transmitter idle
            write_reg(off, data);
            check_all();
        end

        // transmit
        for (i = 0; i < 4; i++)
        begin
            d = 4 + $urandom % 37;
            b = uart_data_t'($urandom);
            write_reg(UART_DR, uart_word_t'(d));
            write_reg(UART_TX, uart_word_t'(b));
            write_reg(UART_CR, 32'h3);
            decode_frame(d, got, ok);
            if (ok)
                compare_byte("uart_tx frame", got, b);
            wait_cr(CR_REQ, 1'b0, 4 * d, "transmit request to clear");
            cr_m[CR_REQ] = 1'b0;
            check_reg(UART_CR, "cr");
        end
        write_reg(UART_CR, 32'h1);              // req without tr_en
        expect_no_start(d);
        check_reg(UART_CR, "cr");
        write_reg(UART_CR, 32'h0);

        // receive
        d = 4 + $urandom % 37;
        write_reg(UART_DR, uart_word_t'(d));
        write_reg(UART_CR, 32'h4);
        for (i = 0; i < 8; i++)
        begin
            b = uart_data_t'($urandom);
            send_frame(d, b, 1'b1);
            wait_cr(CR_RX_VALID, 1'b1, 4 * d, "receive valid flag");
            cr_m[CR_RX_VALID] = 1'b1;
            rx_m = b;
            check_reg(UART_CR, "cr");
            check_reg(UART_RX, "rx_data");
            write_reg(UART_CR, 32'h4);          // writing 0 keeps the flag
            check_reg(UART_CR, "cr");
            write_reg(UART_CR, 32'h4 | (32'h1 << CR_RX_VALID));
            check_reg(UART_CR, "cr");
        end

        // frame error leaves the receive register alone
        send_frame(d, uart_data_t'($urandom), 1'b0);
        wait_cr(CR_FRAME_ERR, 1'b1, 4 * d, "frame error flag");
        cr_m[CR_FRAME_ERR] = 1'b1;
        check_reg(UART_CR, "cr");
        check_reg(UART_RX, "rx_data");
        write_reg(UART_CR, 32'h4);
        check_reg(UART_CR, "cr");
        write_reg(UART_CR, 32'h4 | (32'h1 << CR_FRAME_ERR));
        check_reg(UART_CR, "cr");

        // receiver disabled
        write_reg(UART_CR, 32'h0);
        send_frame(d, uart_data_t'($urandom), 1'b1);
        repeat (2 * d) @(posedge clk);
        check_reg(UART_CR, "cr");
        check_reg(UART_RX, "rx_data");

        // loopback
        @(posedge clk);
        loop_en <= 1'b1;
        for (i = 0; i < 6; i++)
        begin
            d = 4 + $urandom % 37;
            b = uart_data_t'($urandom);
            write_reg(UART_DR, uart_word_t'(d));
            write_reg(UART_TX, uart_word_t'(b));
            write_reg(UART_CR, 32'h7 | (32'h1 << CR_RX_VALID));
            wait_cr(CR_RX_VALID, 1'b1, 14 * d, "loopback byte");
            wait_cr(CR_REQ, 1'b0, 4 * d, "loopback transmit to finish");
            cr_m[CR_REQ]      = 1'b0;
            cr_m[CR_RX_VALID] = 1'b1;
            rx_m = b;
            check_reg(UART_CR, "cr");
            check_reg(UART_RX, "rx_data");
        end

        $display("%0d word errors, %0d byte errors, %0d other failures",
                 word_errors, byte_errors, other_errors);
        if ((word_errors + byte_errors + other_errors) == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule : uart_tb

// File: design/uart_top.sv
// ==============================
// uart_top
// memory-mapped UART peripheral
// ==============================

module uart_top
    import uart_pkg::*;
#(
    parameter int DIV_W = 16
)
(
    input  logic        clk,
    input  logic        rst,
    // bus side
    input  uart_word_t  addr,
    input  logic        we,
    input  uart_word_t  wd,
    output uart_word_t  rd,
    // serial side
    output logic        uart_tx,
    input  logic        uart_rx
);

    logic               en;
    logic               req;
    logic               req_ack;
    logic               tr_en;
    logic               rec_en;
    uart_data_t         tx_data;
    uart_data_t         rx_data;
    logic               rx_done;
    logic               rx_err;
    logic [DIV_W-1 : 0] div;

    uart_regs #(.DIV_W(DIV_W)) uart_regs_0
    (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .addr       ( addr      ),
        .we         ( we        ),
        .wd         ( wd        ),
        .rd         ( rd        ),
        .req        ( req       ),
        .tr_en      ( tr_en     ),
        .tx_data    ( tx_data   ),
        .req_ack    ( req_ack   ),
        .rec_en     ( rec_en    ),
        .rx_data    ( rx_data   ),
        .rx_done    ( rx_done   ),
        .rx_err     ( rx_err    ),
        .div        ( div       )
    );

    uart_baud_gen #(.DIV_W(DIV_W)) uart_baud_gen_0
    (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .div        ( div       ),
        .en         ( en        )
    );

    uart_tx uart_tx_0
    (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .en         ( en        ),      // bit strobe
        .tr_en      ( tr_en     ),
        .req        ( req       ),
        .tx_data    ( tx_data   ),
        .req_ack    ( req_ack   ),
        .uart_tx    ( uart_tx   )
    );

    uart_rx #(.DIV_W(DIV_W)) uart_rx_0
    (
        .clk        ( clk       ),
        .rst        ( rst       ),
        .div        ( div       ),
        .rec_en     ( rec_en    ),
        .uart_rx    ( uart_rx   ),
        .rx_data    ( rx_data   ),
        .rx_done    ( rx_done   ),
        .rx_err     ( rx_err    )
    );

endmodule : uart_top

// File: design/uart_rx.sv
// ==============================
// uart_rx
// 8N1 receiver, mid-bit sampling timed from
// the baud divisor
// ==============================

module uart_rx
    import uart_pkg::*;
#(
    parameter int DIV_W = 16
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DIV_W-1 : 0]  div,
    input  logic                rec_en,
    input  logic                uart_rx,    // serial line
    output uart_data_t          rx_data,
    output logic                rx_done,
    output logic                rx_err
);

    localparam logic [1 : 0] IDLE  = 2'd0;
    localparam logic [1 : 0] START = 2'd1;
    localparam logic [1 : 0] DATA  = 2'd2;
    localparam logic [1 : 0] STOP  = 2'd3;

    logic [1 : 0]       state;
    logic [1 : 0]       rx_sync;    // two-flop synchronizer
    logic               rx_prev;
    logic               rx_s;
    logic               rx_fall;
    logic [DIV_W-1 : 0] cnt;        // cycles to next sample
    logic [DIV_W-1 : 0] div_eff;
    logic [2 : 0]       bit_cnt;
    uart_data_t         shift;

    assign div_eff = (div < DIV_W'(2)) ? DIV_W'(2) : div;
    assign rx_s    = rx_sync[1];
    assign rx_fall = rx_prev && !rx_s;
    assign rx_data = shift;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || !rec_en)
        begin
            state   <= IDLE;            // disable aborts the frame
            cnt     <= '0;
            bit_cnt <= '0;
            rx_done <= 1'b0;
            rx_err  <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            rx_err  <= 1'b0;
            case (state)
                IDLE :
                begin
                    if (rx_fall)
                    begin
                        cnt   <= (div_eff >> 1) - 1'b1;     // half a bit
                        state <= START;
                    end
                end
                START :
                begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else if (!rx_s)
                    begin
                        cnt     <= div_eff - 1'b1;
                        bit_cnt <= '0;
                        state   <= DATA;
                    end
                    else
                        state <= IDLE;          // glitch, drop it
                end
                DATA :
                begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else
                    begin
                        cnt     <= div_eff - 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= STOP;
                    end
                end
                STOP :
                begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else
                    begin
                        rx_done <= rx_s;
                        rx_err  <= !rx_s;       // low stop bit
                        state   <= IDLE;
                    end
                end
                default : state <= IDLE;
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk)
    begin
        if (rec_en && (state == DATA) && (cnt == '0))
            shift <= {rx_s, shift[7 : 1]};
    end

endmodule : uart_rx

// File: design/uart_tx.sv
// ==============================
// uart_tx
// 8N1 transmitter paced by the baud strobe
// ==============================

module uart_tx
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        en,         // bit strobe
    input  logic        tr_en,
    input  logic        req,
    input  uart_data_t  tx_data,
    output logic        req_ack,
    output logic        uart_tx     // serial line
);

    localparam logic [1 : 0] IDLE  = 2'd0;
    localparam logic [1 : 0] SHIFT = 2'd1;
    localparam logic [1 : 0] STOP  = 2'd2;

    logic [1 : 0]   state;
    logic [3 : 0]   bit_cnt;        // data bits already on the line
    uart_data_t     shift;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= IDLE;
            bit_cnt <= '0;
            req_ack <= 1'b0;
            uart_tx <= 1'b1;            // idle line is high
        end
        else
        begin
            req_ack <= 1'b0;
            case (state)
                IDLE :
                begin
                    uart_tx <= 1'b1;
                    if (en && req && tr_en)
                    begin
                        uart_tx <= 1'b0;    // start bit
                        bit_cnt <= '0;
                        state   <= SHIFT;
                    end
                end
                SHIFT :
                begin
                    if (en)
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            uart_tx <= 1'b1;    // stop bit
                            state   <= STOP;
                        end
                        else
                        begin
                            uart_tx <= shift[0];    // lsb first
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                STOP :
                begin
                    if (en)
                    begin
                        req_ack <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default : state <= IDLE;
            endcase
        end
    end

    // byte is latched at the start strobe, then shifted out
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && en && req && tr_en)
            shift <= tx_data;
        else if ((state == SHIFT) && en && (bit_cnt != 4'd8))
            shift <= shift >> 1;
    end

endmodule : uart_tx

// File: design/uart_baud_gen.sv
// ==============================
// uart_baud_gen
// one-cycle bit strobe every div cycles
// ==============================

module uart_baud_gen
#(
    parameter int DIV_W = 16
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic [DIV_W-1 : 0]  div,
    output logic                en
);

    logic [DIV_W-1 : 0] cnt;        // down counter
    logic [DIV_W-1 : 0] div_last;   // divisor seen last cycle
    logic [DIV_W-1 : 0] div_eff;

    assign div_eff = (div < DIV_W'(2)) ? DIV_W'(2) : div;   // clamp to 2

    always_ff @(posedge clk)
    begin
        if (rst || (div != div_last))
        begin
            cnt <= div_eff - 1'b1;      // restart on a new rate
            en  <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt <= div_eff - 1'b1;
            en  <= 1'b1;
        end
        else
        begin
            cnt <= cnt - 1'b1;
            en  <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            div_last <= '0;
        else
            div_last <= div;
    end

endmodule : uart_baud_gen

// File: design/uart_regs.sv
// ==============================
// uart_regs
// register bank of the UART: address decode,
// control and status bits, read mux
// ==============================

module uart_regs
    import uart_pkg::*;
#(
    parameter int DIV_W = 16
)
(
    input  logic                clk,
    input  logic                rst,
    // bus side
    input  uart_word_t          addr,
    input  logic                we,
    input  uart_word_t          wd,
    output uart_word_t          rd,
    // transmitter side
    output logic                req,
    output logic                tr_en,
    output uart_data_t          tx_data,
    input  logic                req_ack,
    // receiver side
    output logic                rec_en,
    input  uart_data_t          rx_data,
    input  logic                rx_done,
    input  logic                rx_err,
    // baud divisor
    output logic [DIV_W-1 : 0]  div
);

    logic [CR_FRAME_ERR : 0]    ctrl;       // control and status bits
    uart_data_t                 rx_reg;     // last received byte
    logic                       cr_we;
    logic                       tx_we;
    logic                       dr_we;

    assign cr_we = we && (addr[3 : 0] == UART_CR);
    assign tx_we = we && (addr[3 : 0] == UART_TX);
    assign dr_we = we && (addr[3 : 0] == UART_DR);

    // bus writes first, hardware events override them
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl <= '0;
        end
        else
        begin
            if (cr_we)
            begin
                ctrl[CR_REQ]    <= wd[CR_REQ];
                ctrl[CR_TR_EN]  <= wd[CR_TR_EN];
                ctrl[CR_REC_EN] <= wd[CR_REC_EN];
                if (wd[CR_RX_VALID])
                    ctrl[CR_RX_VALID] <= 1'b0;      // write 1 to clear
                if (wd[CR_FRAME_ERR])
                    ctrl[CR_FRAME_ERR] <= 1'b0;     // write 1 to clear
            end
            if (req_ack)
                ctrl[CR_REQ] <= 1'b0;               // frame finished
            if (rx_done)
                ctrl[CR_RX_VALID] <= 1'b1;
            if (rx_err)
                ctrl[CR_FRAME_ERR] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tx_data <= '0;
        else if (tx_we)
            tx_data <= wd[7 : 0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            div <= '0;
        else if (dr_we)
            div <= wd[DIV_W-1 : 0];
    end

    // a new byte simply overwrites the old one
    always_ff @(posedge clk)
    begin
        if (rst)
            rx_reg <= '0;
        else if (rx_done)
            rx_reg <= rx_data;
    end

    assign req    = ctrl[CR_REQ];
    assign tr_en  = ctrl[CR_TR_EN];
    assign rec_en = ctrl[CR_REC_EN];

    // read mux, zero extended
    always_comb
    begin
        rd = '0;
        case (addr[3 : 0])
            UART_CR : rd = uart_word_t'(ctrl);
            UART_TX : rd = uart_word_t'(tx_data);
            UART_RX : rd = uart_word_t'(rx_reg);
            UART_DR : rd = uart_word_t'(div);
            default : rd = '0;                      // unmapped offset
        endcase
    end

endmodule : uart_regs

// File: design/uart_pkg.sv
// ==============================
// uart_pkg
// shared types, register offsets and control
// bit positions of the UART peripheral
// ==============================

package uart_pkg;

    // bus side word: address, write data and read data
    typedef logic [31 : 0] uart_word_t;

    // one serial data byte
    typedef logic [7 : 0]  uart_data_t;

    // register offsets, decoded on addr[3:0]
    localparam logic [3 : 0] UART_CR = 4'h0;   // control and status
    localparam logic [3 : 0] UART_TX = 4'h4;   // transmit data
    localparam logic [3 : 0] UART_RX = 4'h8;   // receive data
    localparam logic [3 : 0] UART_DR = 4'hC;   // baud divisor

    // control register bit positions
    localparam int CR_REQ       = 0;    // transmit request
    localparam int CR_TR_EN     = 1;    // transmitter enable
    localparam int CR_REC_EN    = 2;    // receiver enable
    localparam int CR_RX_VALID  = 3;    // byte received, sticky
    localparam int CR_FRAME_ERR = 4;    // bad stop bit, sticky

endpackage : uart_pkg
